//--- tmu_mesh.f
+incdir+design
design/tmu_pkg.sv
design/axil_if.sv
design/tmu_fetch_vertex.sv
design/tmu_square_writer.sv
design/tmu_mem_arbiter.sv
design/tmu_vertex_ram.sv
design/tmu_mesh_top.sv
verification/tmu_mesh_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/100ps \
	--top-module tmu_mesh_tb \
	-f tmu_mesh.f \
	-o tmu_mesh_sim

./obj_dir/tmu_mesh_sim

//--- verification/tmu_mesh_tb.sv
// testbench for the mesh front end with host bus tasks, reference model and record checks.
`default_nettype none
`include "tmu_defines.svh"

module tmu_mesh_tb import tmu_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 5000;
	localparam int MESH_W  = 1 << `TMU_MESH_BITS;
	localparam int CW      = `TMU_COORD_W;
	localparam int DW      = `TMU_DST_W;

	logic                        sys_clk;
	logic                        sys_rst;
	logic [`TMU_ADDR_W-1:0]      s_awaddr_i;
	logic                        s_awvalid_i;
	logic                        s_awready_o;
	logic [`TMU_DATA_W-1:0]      s_wdata_i;
	logic [`TMU_DATA_W/8-1:0]    s_wstrb_i;
	logic                        s_wvalid_i;
	logic                        s_wready_o;
	logic [1:0]                  s_bresp_o;
	logic                        s_bvalid_o;
	logic                        s_bready_i;
	logic [`TMU_ADDR_W-1:0]      s_araddr_i;
	logic                        s_arvalid_i;
	logic                        s_arready_o;
	logic [`TMU_DATA_W-1:0]      s_rdata_o;
	logic [1:0]                  s_rresp_o;
	logic                        s_rvalid_o;
	logic                        s_rready_i;
	logic                        start_i;
	logic [`TMU_MESH_BITS-1:0]   vertex_hlast_i;
	logic [`TMU_MESH_BITS-1:0]   vertex_vlast_i;
	logic [`TMU_ADDR_W-3:0]      vertex_base_i;
	logic [`TMU_ADDR_W-3:0]      out_base_i;
	logic signed [DW-1:0]        dst_hoffset_i;
	logic signed [DW-1:0]        dst_voffset_i;
	logic [DW-2:0]               dst_squarew_i;
	logic [DW-2:0]               dst_squareh_i;
	logic                        busy_o;
	logic [`TMU_DATA_W-1:0]      vtx_x [MESH_W*MESH_W]; // host copy of the vertex words.
	logic [`TMU_DATA_W-1:0]      vtx_y [MESH_W*MESH_W];

	tmu_mesh_top uut (.*);

	always #5 sys_clk = ~sys_clk;

	task automatic abort_run(input string why);
		$display("stopping: %s", why);
		$display("Checks failed");
		$fatal(1, "first error ends the run");
	endtask

	task automatic next_cycle();
		@(posedge sys_clk);
		#1;
	endtask

	function automatic logic [`TMU_ADDR_W-3:0] vertex_word(input int c, input int r,
		input bit is_y);
		return vertex_base_i + (`TMU_ADDR_W-2)'(2 * (r * MESH_W + c) + int'(is_y));
	endfunction

	function automatic logic [`TMU_DATA_W-1:0] sentinel(input logic [`TMU_ADDR_W-3:0] word);
		return {2'b10, word} ^ 32'h5a5a_0f0f;
	endfunction

	function automatic logic [`TMU_DATA_W-1:0] sext_coord(input logic [CW-1:0] v);
		return {{(`TMU_DATA_W-CW){v[CW-1]}}, v};
	endfunction

	function automatic logic [`TMU_DATA_W-1:0] sext_dst(input logic [DW-1:0] v);
		return {{(`TMU_DATA_W-DW){v[DW-1]}}, v};
	endfunction

	// square (c, r) has corners A (c, r), B (c+1, r), C (c, r+1) and D (c+1, r+1).
	function automatic square_t ref_square(input int c, input int r);
		square_t s;
		int      up;
		int      dn;
		int      drx;
		int      dry;
		up    = r * MESH_W + c;
		dn    = (r + 1) * MESH_W + c;
		s.ax  = vtx_x[up][CW-1:0];
		s.ay  = vtx_y[up][CW-1:0];
		s.bx  = vtx_x[up+1][CW-1:0];
		s.by  = vtx_y[up+1][CW-1:0];
		s.cx  = vtx_x[dn][CW-1:0];
		s.cy  = vtx_y[dn][CW-1:0];
		s.dx  = vtx_x[dn+1][CW-1:0];
		s.dy  = vtx_y[dn+1][CW-1:0];
		drx   = int'(dst_hoffset_i) + c * int'(dst_squarew_i);
		dry   = int'(dst_voffset_i) + r * int'(dst_squareh_i);
		s.drx = drx[DW-1:0]; // wraps like the 12-bit destination.
		s.dry = dry[DW-1:0];
		return s;
	endfunction

	task automatic check_word(input string name, input logic [`TMU_DATA_W-1:0] exp,
		input logic [`TMU_DATA_W-1:0] got);
		if (got !== exp) begin
			$display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
			abort_run("data word mismatch");
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e got);
		if (got !== exp) begin
			$display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
			abort_run("bus response mismatch");
		end
	endtask

	task automatic check_square(input string name, input square_t exp, input square_t got);
		if (got !== exp) begin
			$display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
			abort_run("square record mismatch");
		end
	endtask

	task automatic host_write(input logic [`TMU_ADDR_W-3:0] word,
		input logic [`TMU_DATA_W-1:0] data, input logic [3:0] strb, output axi_resp_e resp);
		int cyc;
		s_awaddr_i  = {word, 2'b00};
		s_wdata_i   = data;
		s_wstrb_i   = strb;
		s_awvalid_i = 1'b1;
		s_wvalid_i  = 1'b1;
		s_bready_i  = 1'b1;
		cyc = 0;
		do begin
			@(negedge sys_clk);
			cyc++;
			if (cyc > TIMEOUT)
				abort_run("host write address was never accepted");
		end while (!s_awready_o);
		if (!s_wready_o)
			abort_run("host write data was not accepted together with its address");
		next_cycle();
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		cyc = 0;
		do begin
			@(negedge sys_clk);
			cyc++;
			if (cyc > TIMEOUT)
				abort_run("host write response never came back");
		end while (!s_bvalid_o);
		resp = axi_resp_e'(s_bresp_o);
		next_cycle();
		s_bready_i = 1'b0;
	endtask

	task automatic host_read(input logic [`TMU_ADDR_W-3:0] word,
		output logic [`TMU_DATA_W-1:0] data, output axi_resp_e resp);
		int cyc;
		s_araddr_i  = {word, 2'b00};
		s_arvalid_i = 1'b1;
		s_rready_i  = 1'b1;
		cyc = 0;
		do begin
			@(negedge sys_clk);
			cyc++;
			if (cyc > TIMEOUT)
				abort_run("host read address was never accepted");
		end while (!s_arready_o);
		next_cycle();
		s_arvalid_i = 1'b0;
		cyc = 0;
		do begin
			@(negedge sys_clk);
			cyc++;
			if (cyc > TIMEOUT)
				abort_run("host read data never came back");
		end while (!s_rvalid_o);
		data = s_rdata_o;
		resp = axi_resp_e'(s_rresp_o);
		next_cycle();
		s_rready_i = 1'b0;
	endtask

	task automatic store_word(input logic [`TMU_ADDR_W-3:0] word,
		input logic [`TMU_DATA_W-1:0] data);
		axi_resp_e resp;
		host_write(word, data, 4'hf, resp);
		check_resp("s_bresp_o", RESP_OKAY, resp);
	endtask

	task automatic load_word(input logic [`TMU_ADDR_W-3:0] word,
		output logic [`TMU_DATA_W-1:0] data);
		axi_resp_e resp;
		host_read(word, data, resp);
		check_resp("s_rresp_o", RESP_OKAY, resp);
	endtask

	task automatic wait_busy(input logic level);
		int cyc;
		cyc = 0;
		do begin
			@(negedge sys_clk);
			cyc++;
			if (cyc > TIMEOUT)
				abort_run($sformatf("busy_o did not reach %0b in time", level));
		end while (busy_o !== level);
		next_cycle();
	endtask

	task automatic run_mesh();
		start_i = 1'b1;
		next_cycle();
		start_i = 1'b0;
		wait_busy(1'b1);
	endtask

	task automatic verify_record(input logic [`TMU_ADDR_W-3:0] base, input square_t exp);
		logic [`TMU_DATA_W-1:0] w [10];
		logic [`TMU_DATA_W-1:0] want [10];
		square_t                got;
		for (int i = 0; i < 10; i++)
			load_word(base + (`TMU_ADDR_W-2)'(i), w[i]);
		got = {w[0][CW-1:0], w[1][CW-1:0], w[2][CW-1:0], w[3][CW-1:0],
			w[4][CW-1:0], w[5][CW-1:0], w[6][CW-1:0], w[7][CW-1:0],
			w[8][DW-1:0], w[9][DW-1:0]};
		check_square($sformatf("square from s_rdata_o at word 0x%h", base), exp, got);
		for (int i = 0; i < 8; i++)
			want[i] = sext_coord(exp[$bits(square_t)-1-CW*i -: CW]);
		want[8] = sext_dst(exp.drx);
		want[9] = sext_dst(exp.dry);
		for (int i = 0; i < 10; i++) // upper bits carry the sign.
			check_word($sformatf("s_rdata_o at word 0x%h", base + (`TMU_ADDR_W-2)'(i)),
				want[i], w[i]);
	endtask

	initial begin
		axi_resp_e              resp;
		logic [`TMU_DATA_W-1:0] data;
		void'($urandom(32'hcdb));
		sys_clk        = 1'b0;
		sys_rst        = 1'b1;
		s_awaddr_i     = '0;
		s_awvalid_i    = 1'b0;
		s_wdata_i      = '0;
		s_wstrb_i      = '0;
		s_wvalid_i     = 1'b0;
		s_bready_i     = 1'b0;
		s_araddr_i     = '0;
		s_arvalid_i    = 1'b0;
		s_rready_i     = 1'b0;
		start_i        = 1'b0;
		vertex_hlast_i = 3'd3; // 4 by 3 vertices.
		vertex_vlast_i = 3'd2;
		vertex_base_i  = 30'd100;
		out_base_i     = 30'd400;
		dst_hoffset_i  = -12'sd40;
		dst_voffset_i  = -12'sd7;
		dst_squarew_i  = 11'd23;
		dst_squareh_i  = 11'd17;
		repeat (16) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;

		store_word(30'd1500, 32'h1234_5678);
		load_word(30'd1500, data);
		check_word("s_rdata_o", 32'h1234_5678, data);
		host_write(30'd1500, 32'haabb_ccdd, 4'b0101, resp);
		check_resp("s_bresp_o", RESP_OKAY, resp);
		load_word(30'd1500, data);
		check_word("s_rdata_o", 32'h12bb_56dd, data); // lanes 0 and 2 only.

		for (int r = 0; r <= int'(vertex_vlast_i); r++) begin
			for (int c = 0; c <= int'(vertex_hlast_i); c++) begin
				vtx_x[r*MESH_W+c] = $urandom();
				vtx_y[r*MESH_W+c] = $urandom();
				store_word(vertex_word(c, r, 1'b0), vtx_x[r*MESH_W+c]);
				store_word(vertex_word(c, r, 1'b1), vtx_y[r*MESH_W+c]);
			end
		end
		run_mesh();
		for (int c = 0; c <= int'(vertex_hlast_i); c++) begin // competes with the run.
			load_word(vertex_word(c, 1, 1'b0), data);
			check_word("s_rdata_o", vtx_x[MESH_W+c], data);
		end
		if (!busy_o)
			abort_run("the run ended before the host reads were issued");
		wait_busy(1'b0);
		for (int r = 0; r < int'(vertex_vlast_i); r++)
			for (int c = 0; c < int'(vertex_hlast_i); c++)
				verify_record(out_base_i + 30'((r * int'(vertex_hlast_i) + c)
					* `TMU_REC_STRIDE), ref_square(c, r));

		host_write(30'(`TMU_MEM_WORDS + 5), 32'hdead_beef, 4'hf, resp);
		check_resp("s_bresp_o", RESP_SLVERR, resp);
		host_read(30'(`TMU_MEM_WORDS + 5), data, resp);
		check_resp("s_rresp_o", RESP_SLVERR, resp);
		check_word("s_rdata_o", '0, data);

		vertex_hlast_i = 3'd1; // 2 by 2 vertices, one square.
		vertex_vlast_i = 3'd1;
		out_base_i     = 30'd800;
		dst_hoffset_i  = 12'sd5;
		dst_voffset_i  = -12'sd300;
		dst_squarew_i  = 11'd40;
		dst_squareh_i  = 11'd9;
		for (int i = 0; i < 2 * `TMU_REC_STRIDE; i++)
			store_word(out_base_i + 30'(i), sentinel(out_base_i + 30'(i)));
		run_mesh();
		wait_busy(1'b0);
		verify_record(out_base_i, ref_square(0, 0));
		for (int i = 10; i < 2 * `TMU_REC_STRIDE; i++) begin
			load_word(out_base_i + 30'(i), data);
			check_word($sformatf("s_rdata_o at word 0x%h", out_base_i + 30'(i)),
				sentinel(out_base_i + 30'(i)), data);
		end

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/tmu_mesh_top.sv
// mesh front end top level with host port mapping, fetcher, writer, arbiter and memory.
`default_nettype none
`include "tmu_defines.svh"

module tmu_mesh_top import tmu_pkg::*; (
	input  wire                         sys_clk,
	input  wire                         sys_rst,
	input  wire [`TMU_ADDR_W-1:0]       s_awaddr_i,
	input  wire                         s_awvalid_i,
	output logic                        s_awready_o,
	input  wire [`TMU_DATA_W-1:0]       s_wdata_i,
	input  wire [`TMU_DATA_W/8-1:0]     s_wstrb_i,
	input  wire                         s_wvalid_i,
	output logic                        s_wready_o,
	output logic [1:0]                  s_bresp_o,
	output logic                        s_bvalid_o,
	input  wire                         s_bready_i,
	input  wire [`TMU_ADDR_W-1:0]       s_araddr_i,
	input  wire                         s_arvalid_i,
	output logic                        s_arready_o,
	output logic [`TMU_DATA_W-1:0]      s_rdata_o,
	output logic [1:0]                  s_rresp_o,
	output logic                        s_rvalid_o,
	input  wire                         s_rready_i,
	input  wire                         start_i,
	input  wire [`TMU_MESH_BITS-1:0]    vertex_hlast_i,
	input  wire [`TMU_MESH_BITS-1:0]    vertex_vlast_i,
	input  wire [`TMU_ADDR_W-3:0]       vertex_base_i,
	input  wire [`TMU_ADDR_W-3:0]       out_base_i,
	input  wire signed [`TMU_DST_W-1:0] dst_hoffset_i,
	input  wire signed [`TMU_DST_W-1:0] dst_voffset_i,
	input  wire [`TMU_DST_W-2:0]        dst_squarew_i,
	input  wire [`TMU_DST_W-2:0]        dst_squareh_i,
	output logic                        busy_o
);
	logic    fetch_busy;
	logic    sq_valid;
	logic    sq_ready;
	square_t square;

	axil_if host ();
	axil_if fetch ();
	axil_if wr ();
	axil_if mem ();

	// host port onto the host bus.
	assign host.awaddr  = s_awaddr_i;
	assign host.awvalid = s_awvalid_i;
	assign host.wdata   = s_wdata_i;
	assign host.wstrb   = s_wstrb_i;
	assign host.wvalid  = s_wvalid_i;
	assign host.bready  = s_bready_i;
	assign host.araddr  = s_araddr_i;
	assign host.arvalid = s_arvalid_i;
	assign host.rready  = s_rready_i;
	assign s_awready_o  = host.awready;
	assign s_wready_o   = host.wready;
	assign s_bresp_o    = host.bresp;
	assign s_bvalid_o   = host.bvalid;
	assign s_arready_o  = host.arready;
	assign s_rdata_o    = host.rdata;
	assign s_rresp_o    = host.rresp;
	assign s_rvalid_o   = host.rvalid;

	tmu_fetch_vertex u_fetch (
		.sys_clk, .sys_rst, .start_i, .vertex_hlast_i, .vertex_vlast_i, .vertex_base_i,
		.dst_hoffset_i, .dst_voffset_i, .dst_squarew_i, .dst_squareh_i,
		.busy_o(fetch_busy), .bus(fetch),
		.sq_valid_o(sq_valid), .sq_ready_i(sq_ready), .square_o(square)
	);

	tmu_square_writer u_writer (
		.sys_clk, .sys_rst, .fetch_busy_i(fetch_busy), .out_base_i,
		.sq_valid_i(sq_valid), .sq_ready_o(sq_ready), .square_i(square),
		.bus(wr), .busy_o
	);

	tmu_mem_arbiter u_arbiter (
		.sys_clk, .sys_rst, .host_s(host), .fetch_s(fetch), .wr_s(wr), .mem_m(mem)
	);

	tmu_vertex_ram u_ram (.sys_clk, .sys_rst, .bus(mem));

endmodule

`default_nettype wire

//--- design/tmu_vertex_ram.sv
// single-port word memory behind an AXI4-Lite slave with SLVERR for out-of-range addresses.
`default_nettype none
`include "tmu_defines.svh"

module tmu_vertex_ram import tmu_pkg::*; (
	input  wire   sys_clk,
	input  wire   sys_rst,
	axil_if.slave bus
);
	localparam int IDX_W = $clog2(`TMU_MEM_WORDS);

	logic [`TMU_DATA_W-1:0] mem [`TMU_MEM_WORDS];
	logic [IDX_W-1:0]       wr_idx;
	logic [IDX_W-1:0]       rd_idx;
	logic                   wr_oor;
	logic                   rd_oor;
	logic                   idle;

	assign wr_idx = bus.awaddr[IDX_W+1:2];
	assign rd_idx = bus.araddr[IDX_W+1:2];
	assign wr_oor = bus.awaddr[`TMU_ADDR_W-1:2] >= `TMU_MEM_WORDS;
	assign rd_oor = bus.araddr[`TMU_ADDR_W-1:2] >= `TMU_MEM_WORDS;
	assign idle   = !bus.awready && !bus.arready && !bus.bvalid && !bus.rvalid;

	always_ff @(posedge sys_clk) begin
		if (bus.awvalid && bus.awready && !wr_oor) begin
			for (int b = 0; b < `TMU_DATA_W/8; b++)
				if (bus.wstrb[b])
					mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
		end
		if (bus.arvalid && bus.arready)
			bus.rdata <= rd_oor ? '0 : mem[rd_idx];
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			bus.awready <= 1'b0;
			bus.wready  <= 1'b0;
			bus.arready <= 1'b0;
			bus.bvalid  <= 1'b0;
			bus.rvalid  <= 1'b0;
			bus.bresp   <= RESP_OKAY;
			bus.rresp   <= RESP_OKAY;
		end else begin
			bus.awready <= 1'b0; // ready is a one-cycle pulse.
			bus.wready  <= 1'b0;
			bus.arready <= 1'b0;
			if (bus.bvalid && bus.bready)
				bus.bvalid <= 1'b0;
			if (bus.rvalid && bus.rready)
				bus.rvalid <= 1'b0;
			if (bus.awvalid && bus.awready) begin
				bus.bvalid <= 1'b1;
				bus.bresp  <= wr_oor ? RESP_SLVERR : RESP_OKAY;
			end
			if (bus.arvalid && bus.arready) begin
				bus.rvalid <= 1'b1;
				bus.rresp  <= rd_oor ? RESP_SLVERR : RESP_OKAY;
			end
			if (idle && bus.awvalid && bus.wvalid) begin // writes go first.
				bus.awready <= 1'b1;
				bus.wready  <= 1'b1;
			end else if (idle && bus.arvalid) begin
				bus.arready <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/tmu_mem_arbiter.sv
// round-robin arbiter granting the memory to one of three AXI4-Lite masters per transaction.
`default_nettype none

module tmu_mem_arbiter (
	input  wire    sys_clk,
	input  wire    sys_rst,
	axil_if.slave  host_s,
	axil_if.slave  fetch_s,
	axil_if.slave  wr_s,
	axil_if.master mem_m
);
	logic [2:0] req;
	logic [2:0] pick;
	logic [2:0] gnt;
	logic [2:0] gnt_q;
	logic [1:0] last_q;
	logic       open_q;
	logic       done;

	// bit 0 host, bit 1 fetcher, bit 2 writer.
	assign req = {wr_s.awvalid | wr_s.arvalid,
		fetch_s.awvalid | fetch_s.arvalid,
		host_s.awvalid | host_s.arvalid};

	always_comb begin
		int idx;
		pick = '0;
		for (int k = 1; k <= 3; k++) begin // search starts after the last winner.
			idx = (int'(last_q) + k) % 3;
			if (pick == '0 && req[idx])
				pick[idx] = 1'b1;
		end
	end

	assign gnt  = open_q ? gnt_q : pick;
	assign done = (mem_m.bvalid && mem_m.bready) || (mem_m.rvalid && mem_m.rready);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			open_q <= 1'b0;
			gnt_q  <= '0;
			last_q <= 2'd2; // host wins the first round.
		end else if (open_q) begin
			if (done)
				open_q <= 1'b0;
		end else if (|pick) begin
			open_q <= 1'b1;
			gnt_q  <= pick;
			last_q <= pick[2] ? 2'd2 : (pick[1] ? 2'd1 : 2'd0);
		end
	end

	assign mem_m.awaddr  = gnt[2] ? wr_s.awaddr : (gnt[1] ? fetch_s.awaddr : host_s.awaddr);
	assign mem_m.wdata   = gnt[2] ? wr_s.wdata : (gnt[1] ? fetch_s.wdata : host_s.wdata);
	assign mem_m.wstrb   = gnt[2] ? wr_s.wstrb : (gnt[1] ? fetch_s.wstrb : host_s.wstrb);
	assign mem_m.araddr  = gnt[2] ? wr_s.araddr : (gnt[1] ? fetch_s.araddr : host_s.araddr);
	assign mem_m.awvalid = |(gnt & {wr_s.awvalid, fetch_s.awvalid, host_s.awvalid});
	assign mem_m.wvalid  = |(gnt & {wr_s.wvalid, fetch_s.wvalid, host_s.wvalid});
	assign mem_m.bready  = |(gnt & {wr_s.bready, fetch_s.bready, host_s.bready});
	assign mem_m.arvalid = |(gnt & {wr_s.arvalid, fetch_s.arvalid, host_s.arvalid});
	assign mem_m.rready  = |(gnt & {wr_s.rready, fetch_s.rready, host_s.rready});

	// handshakes reach only the granted master.
	assign host_s.awready  = gnt[0] & mem_m.awready;
	assign host_s.wready   = gnt[0] & mem_m.wready;
	assign host_s.bvalid   = gnt[0] & mem_m.bvalid;
	assign host_s.arready  = gnt[0] & mem_m.arready;
	assign host_s.rvalid   = gnt[0] & mem_m.rvalid;
	assign host_s.bresp    = mem_m.bresp;
	assign host_s.rresp    = mem_m.rresp;
	assign host_s.rdata    = mem_m.rdata;

	assign fetch_s.awready = gnt[1] & mem_m.awready;
	assign fetch_s.wready  = gnt[1] & mem_m.wready;
	assign fetch_s.bvalid  = gnt[1] & mem_m.bvalid;
	assign fetch_s.arready = gnt[1] & mem_m.arready;
	assign fetch_s.rvalid  = gnt[1] & mem_m.rvalid;
	assign fetch_s.bresp   = mem_m.bresp;
	assign fetch_s.rresp   = mem_m.rresp;
	assign fetch_s.rdata   = mem_m.rdata;

	assign wr_s.awready    = gnt[2] & mem_m.awready;
	assign wr_s.wready     = gnt[2] & mem_m.wready;
	assign wr_s.bvalid     = gnt[2] & mem_m.bvalid;
	assign wr_s.arready    = gnt[2] & mem_m.arready;
	assign wr_s.rvalid     = gnt[2] & mem_m.rvalid;
	assign wr_s.bresp      = mem_m.bresp;
	assign wr_s.rresp      = mem_m.rresp;
	assign wr_s.rdata      = mem_m.rdata;

	// memory accepts and responds only inside a granted transaction.
	mem_in_open: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(mem_m.awready || mem_m.arready || mem_m.bvalid || mem_m.rvalid) |-> open_q);

endmodule

`default_nettype wire

//--- design/tmu_square_writer.sv
// square writer that stores ten-word records over AXI4-Lite and tracks run completion.
`default_nettype none
`include "tmu_defines.svh"

module tmu_square_writer import tmu_pkg::*; (
	input  wire                   sys_clk,
	input  wire                   sys_rst,
	input  wire                   fetch_busy_i,
	input  wire [`TMU_ADDR_W-3:0] out_base_i,
	input  wire                   sq_valid_i,
	output logic                  sq_ready_o,
	input  wire square_t          square_i,
	axil_if.master                bus,
	output logic                  busy_o
);
	wr_state_e                     state_q;
	square_t                       sq_q;
	logic [3:0]                    word_q;
	logic [2*`TMU_MESH_BITS-1:0]   rec_q;
	logic [`TMU_ADDR_W-3:0]        word_addr;

	assign sq_ready_o = (state_q == WR_IDLE);
	assign busy_o     = fetch_busy_i || (state_q != WR_IDLE);

	// write-only master, read channels idle.
	assign bus.araddr  = '0;
	assign bus.arvalid = 1'b0;
	assign bus.rready  = 1'b0;

	assign word_addr   = out_base_i + (`TMU_ADDR_W-2)'(rec_q * `TMU_REC_STRIDE + word_q);
	assign bus.awaddr  = {word_addr, 2'b00};
	assign bus.awvalid = (state_q == WR_ADDR);
	assign bus.wvalid  = (state_q == WR_ADDR);
	assign bus.wstrb   = '1;
	assign bus.bready  = (state_q == WR_RESP);

	always_comb begin
		case (word_q) // sign-extended record words.
			4'd0:    bus.wdata = (`TMU_DATA_W)'(sq_q.ax);
			4'd1:    bus.wdata = (`TMU_DATA_W)'(sq_q.ay);
			4'd2:    bus.wdata = (`TMU_DATA_W)'(sq_q.bx);
			4'd3:    bus.wdata = (`TMU_DATA_W)'(sq_q.by);
			4'd4:    bus.wdata = (`TMU_DATA_W)'(sq_q.cx);
			4'd5:    bus.wdata = (`TMU_DATA_W)'(sq_q.cy);
			4'd6:    bus.wdata = (`TMU_DATA_W)'(sq_q.dx);
			4'd7:    bus.wdata = (`TMU_DATA_W)'(sq_q.dy);
			4'd8:    bus.wdata = (`TMU_DATA_W)'(sq_q.drx);
			default: bus.wdata = (`TMU_DATA_W)'(sq_q.dry);
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sq_valid_i && sq_ready_o)
			sq_q <= square_i;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state_q <= WR_IDLE;
			word_q  <= '0;
			rec_q   <= '0;
		end else begin
			case (state_q)
				WR_IDLE: begin
					word_q <= '0;
					if (!fetch_busy_i)
						rec_q <= '0; // run over, next one starts at record 0.
					if (sq_valid_i)
						state_q <= WR_ADDR;
				end
				WR_ADDR: begin
					if (bus.awready && bus.wready)
						state_q <= WR_RESP;
				end
				WR_RESP: begin
					if (bus.bvalid && word_q == 4'd9) begin
						rec_q   <= rec_q + 1'b1;
						state_q <= WR_IDLE;
					end else if (bus.bvalid) begin
						word_q  <= word_q + 1'b1;
						state_q <= WR_ADDR;
					end
				end
				default: state_q <= WR_IDLE;
			endcase
		end
	end

	// records are placed in range by the host setup.
	b_okay: assert property (@(posedge sys_clk) disable iff (sys_rst)
		bus.bvalid |-> bus.bresp == RESP_OKAY);

endmodule

`default_nettype wire

//--- design/tmu_fetch_vertex.sv
// vertex fetcher with fetch engine, position generator and square handoff FSM.
`default_nettype none
`include "tmu_defines.svh"

module tmu_fetch_vertex import tmu_pkg::*; (
	input  wire                          sys_clk,
	input  wire                          sys_rst,
	input  wire                          start_i,
	input  wire [`TMU_MESH_BITS-1:0]     vertex_hlast_i,
	input  wire [`TMU_MESH_BITS-1:0]     vertex_vlast_i,
	input  wire [`TMU_ADDR_W-3:0]        vertex_base_i,
	input  wire signed [`TMU_DST_W-1:0]  dst_hoffset_i,
	input  wire signed [`TMU_DST_W-1:0]  dst_voffset_i,
	input  wire [`TMU_DST_W-2:0]         dst_squarew_i,
	input  wire [`TMU_DST_W-2:0]         dst_squareh_i,
	output logic                         busy_o,
	axil_if.master                       bus,
	output logic                         sq_valid_o,
	input  wire                          sq_ready_i,
	output square_t                      square_o
);
	fetch_state_e                   state_q;
	fetch_state_e                   state_d;
	corner_e                        fetch_target;
	logic                           fetch_strobe;
	logic                           fetch_done_q;
	logic                           is_y_q;
	logic                           shift_points;
	logic                           move_reset;
	logic                           move_x_right;
	logic                           move_x_startline;
	logic                           move_y_down;
	logic                           move_y_up;
	logic [`TMU_MESH_BITS-1:0]      x_q;
	logic [`TMU_MESH_BITS-1:0]      y_q;
	logic signed [`TMU_DST_W-1:0]   drx_q;
	logic signed [`TMU_DST_W-1:0]   dry_q;
	logic signed [`TMU_DST_W-1:0]   step_w;
	logic signed [`TMU_DST_W-1:0]   step_h;
	logic signed [`TMU_COORD_W-1:0] vx_q [4];
	logic signed [`TMU_COORD_W-1:0] vy_q [4];
	logic [`TMU_ADDR_W-3:0]         word_addr;

	// read-only master, write channels idle.
	assign bus.awaddr  = '0;
	assign bus.awvalid = 1'b0;
	assign bus.wdata   = '0;
	assign bus.wstrb   = '0;
	assign bus.wvalid  = 1'b0;
	assign bus.bready  = 1'b0;

	// x word then y word of vertex (x_q, y_q).
	assign word_addr  = vertex_base_i + (`TMU_ADDR_W-2)'({y_q, x_q, is_y_q});
	assign bus.araddr = {word_addr, 2'b00};

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			bus.arvalid  <= 1'b0;
			bus.rready   <= 1'b0;
			is_y_q       <= 1'b0;
			fetch_done_q <= 1'b0;
		end else begin
			fetch_done_q <= 1'b0;
			if (bus.arvalid && bus.arready) begin
				bus.arvalid <= 1'b0;
				bus.rready  <= 1'b1; // wait for the data beat.
			end else if (fetch_strobe && !fetch_done_q && !bus.arvalid && !bus.rready) begin
				bus.arvalid <= 1'b1;
			end
			if (bus.rvalid && bus.rready) begin
				bus.rready   <= 1'b0;
				is_y_q       <= !is_y_q;
				fetch_done_q <= is_y_q; // corner done after its y word.
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (bus.rvalid && bus.rready) begin
			if (is_y_q)
				vy_q[fetch_target] <= bus.rdata[`TMU_COORD_W-1:0];
			else
				vx_q[fetch_target] <= bus.rdata[`TMU_COORD_W-1:0];
		end
		if (shift_points) begin // right corners become the left ones.
			vx_q[CORNER_A] <= vx_q[CORNER_B];
			vy_q[CORNER_A] <= vy_q[CORNER_B];
			vx_q[CORNER_C] <= vx_q[CORNER_D];
			vy_q[CORNER_C] <= vy_q[CORNER_D];
		end
	end

	assign step_w = $signed({1'b0, dst_squarew_i});
	assign step_h = $signed({1'b0, dst_squareh_i});

	// destination tracks the D corner, so it starts one square back.
	always_ff @(posedge sys_clk) begin
		if (sys_rst || move_reset) begin
			x_q   <= '0;
			y_q   <= '0;
			drx_q <= dst_hoffset_i - step_w;
			dry_q <= dst_voffset_i - step_h;
		end else begin
			if (move_x_right) begin
				x_q   <= x_q + 1'b1;
				drx_q <= drx_q + step_w;
			end else if (move_x_startline) begin
				x_q   <= '0;
				drx_q <= dst_hoffset_i - step_w;
			end
			if (move_y_down) begin
				y_q   <= y_q + 1'b1;
				dry_q <= dry_q + step_h;
			end else if (move_y_up) begin
				y_q   <= y_q - 1'b1;
				dry_q <= dry_q - step_h;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d          = state_q;
		fetch_target     = CORNER_A;
		fetch_strobe     = 1'b0;
		shift_points     = 1'b0;
		move_reset       = 1'b0;
		move_x_right     = 1'b0;
		move_x_startline = 1'b0;
		move_y_down      = 1'b0;
		move_y_up        = 1'b0;
		case (state_q)
			IDLE: begin
				move_reset = 1'b1;
				if (start_i)
					state_d = FETCH_A;
			end
			FETCH_A: begin
				fetch_strobe = 1'b1;
				if (fetch_done_q) begin
					move_y_down = 1'b1;
					state_d     = FETCH_C;
				end
			end
			FETCH_C: begin
				fetch_target = CORNER_C;
				fetch_strobe = 1'b1;
				if (fetch_done_q) begin
					move_x_right = 1'b1;
					move_y_up    = 1'b1;
					state_d      = FETCH_B;
				end
			end
			FETCH_B: begin
				fetch_target = CORNER_B;
				fetch_strobe = 1'b1;
				if (fetch_done_q) begin
					move_y_down = 1'b1;
					state_d     = FETCH_D;
				end
			end
			FETCH_D: begin
				fetch_target = CORNER_D;
				fetch_strobe = 1'b1;
				if (fetch_done_q)
					state_d = PIPEOUT;
			end
			PIPEOUT: begin
				if (sq_ready_i)
					state_d = NEXT_SQUARE;
			end
			NEXT_SQUARE: begin // position is at corner D here.
				if (x_q == vertex_hlast_i) begin
					if (y_q == vertex_vlast_i) begin
						state_d = IDLE;
					end else begin
						move_x_startline = 1'b1;
						state_d          = FETCH_A;
					end
				end else begin
					move_x_right = 1'b1;
					move_y_up    = 1'b1;
					shift_points = 1'b1;
					state_d      = FETCH_B;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	assign busy_o     = (state_q != IDLE);
	assign sq_valid_o = (state_q == PIPEOUT);
	assign square_o   = '{
		ax: vx_q[CORNER_A], ay: vy_q[CORNER_A],
		bx: vx_q[CORNER_B], by: vy_q[CORNER_B],
		cx: vx_q[CORNER_C], cy: vy_q[CORNER_C],
		dx: vx_q[CORNER_D], dy: vy_q[CORNER_D],
		drx: drx_q, dry: dry_q
	};

	// a read request may not be withdrawn or moved before the arbiter and memory take it.
	ar_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		bus.arvalid && !bus.arready |=> bus.arvalid && $stable(bus.araddr));

	// vertex addresses must land inside the memory.
	r_okay: assert property (@(posedge sys_clk) disable iff (sys_rst)
		bus.rvalid |-> bus.rresp == RESP_OKAY);

endmodule

`default_nettype wire

//--- design/axil_if.sv
// AXI4-Lite interface with master and slave modports.
`default_nettype none
`include "tmu_defines.svh"

interface axil_if import tmu_pkg::*; ();
	logic [`TMU_ADDR_W-1:0]   awaddr;
	logic                     awvalid;
	logic                     awready;
	logic [`TMU_DATA_W-1:0]   wdata;
	logic [`TMU_DATA_W/8-1:0] wstrb;
	logic                     wvalid;
	logic                     wready;
	axi_resp_e                bresp;
	logic                     bvalid;
	logic                     bready;
	logic [`TMU_ADDR_W-1:0]   araddr;
	logic                     arvalid;
	logic                     arready;
	logic [`TMU_DATA_W-1:0]   rdata;
	axi_resp_e                rresp;
	logic                     rvalid;
	logic                     rready;

	modport master (
		output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
		input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

	modport slave (
		input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
		output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);
endinterface

`default_nettype wire

//--- design/tmu_pkg.sv
// package with the FSM and opcode enums and the square record struct.
`default_nettype none
`include "tmu_defines.svh"

package tmu_pkg;

	typedef enum logic [2:0] {
		IDLE,
		FETCH_A,
		FETCH_C,
		FETCH_B,
		FETCH_D,
		PIPEOUT,
		NEXT_SQUARE
	} fetch_state_e;

	typedef enum logic [1:0] {CORNER_A, CORNER_B, CORNER_C, CORNER_D} corner_e;

	typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_RESP} wr_state_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	// corners A B on top, C D below, plus the destination corner.
	typedef struct packed {
		logic signed [`TMU_COORD_W-1:0] ax, ay;
		logic signed [`TMU_COORD_W-1:0] bx, by;
		logic signed [`TMU_COORD_W-1:0] cx, cy;
		logic signed [`TMU_COORD_W-1:0] dx, dy;
		logic signed [`TMU_DST_W-1:0]   drx, dry;
	} square_t;

endpackage

`default_nettype wire

//--- design/tmu_defines.svh
// bus, memory, mesh and coordinate width macros for the mesh front end.
`ifndef TMU_DEFINES_SVH
`define TMU_DEFINES_SVH

// AXI4-Lite byte address and data widths.
`define TMU_ADDR_W 32
`define TMU_DATA_W 32

// on-chip memory depth in words.
`define TMU_MEM_WORDS 2048

// mesh indices, texture and destination coordinates.
`define TMU_MESH_BITS 3
`define TMU_COORD_W 18
`define TMU_DST_W 12

// word spacing between square records.
`define TMU_REC_STRIDE 16

`endif
